/* coreConsts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// ------------------------------
// datapath sizing
`define XLEN       64
`define NUM_REGS   32

`define RESET_PC   64'h0000_0000_0000_0000  // first fetch address

// ------------------------------
// RV64I base opcodes kept by the core
`define OP_LUI     7'b0110111
`define OP_AUIPC   7'b0010111
`define OP_JAL     7'b1101111
`define OP_JALR    7'b1100111
`define OP_BRANCH  7'b1100011
`define OP_IMM     7'b0010011
`define OP_REG     7'b0110011

`endif

/* corePkg.sv */
`include "coreConsts.svh"

package corePkg;

    typedef logic [`XLEN-1:0] xlenT;    // data word or address
    typedef logic [31:0]      instrT;
    typedef logic [4:0]       regIdxT;
    typedef logic [2:0]       funct3T;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra
    } aluOpT;

    // source of ALU operand A
    typedef enum logic [1:0] {
        selReg,
        selZero,    // lui
        selPc       // auipc
    } opASelT;

    // ------------------------------
    typedef struct packed {
        logic   valid;
        regIdxT rs1;
        regIdxT rs2;
        regIdxT rd;
        logic   regWrite;
        logic   aluSrcImm;  // operand B from imm
        aluOpT  aluOp;
        opASelT opASel;
        logic   isBranch;
        logic   isJal;
        logic   isJalr;
        funct3T funct3;     // branch condition
        xlenT   imm;
    } decodeT;

    typedef struct packed {
        xlenT   pc;
        instrT  instr;
        decodeT decode;
        xlenT   rs1Data;
        xlenT   rs2Data;
    } idExT;

    typedef struct packed {
        logic valid;
        xlenT target;
    } redirectT;

    typedef struct packed {
        logic   wen;
        regIdxT rd;
        xlenT   data;
    } wbT;

    typedef struct packed {
        logic   valid;
        xlenT   pc;
        instrT  instr;
        logic   wen;
        regIdxT rd;
        xlenT   data;
    } commitT;

endpackage

/* instrDecoder.sv */
`timescale 1ns/100ps
`include "coreConsts.svh"

module instrDecoder (
    input  corePkg::instrT  instr,
    output corePkg::decodeT dec
);
    import corePkg::*;

    logic [6:0] opcode;
    funct3T     funct3;
    logic       funct7Alt;  // instr[30] selects sub and sra
    xlenT       immI;
    xlenT       immU;
    xlenT       immJ;
    xlenT       immB;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7Alt = instr[30];

    // ------------------------------
    // immediates sign extended to XLEN
    assign immI = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign immU = {{(`XLEN-32){instr[31]}}, instr[31:12], 12'b0};
    assign immJ = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12],
                   instr[20], instr[30:21], 1'b0};
    assign immB = {{(`XLEN-13){instr[31]}}, instr[31], instr[7],
                   instr[30:25], instr[11:8], 1'b0};

    // shared by register and immediate forms
    function automatic aluOpT funct3ToOp(funct3T f3, logic alt);
        case (f3)
            3'b000:  return alt ? aluSub : aluAdd;
            3'b001:  return aluSll;
            3'b010:  return aluSlt;
            3'b011:  return aluSltu;
            3'b100:  return aluXor;
            3'b101:  return alt ? aluSra : aluSrl;
            3'b110:  return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    always_comb begin
        dec        = '0;
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.rd     = instr[11:7];
        dec.funct3 = funct3;
        case (opcode)
            `OP_REG: begin
                dec.valid    = !instr[25];  // M extension not present
                dec.regWrite = 1'b1;
                dec.aluOp    = funct3ToOp(funct3, funct7Alt);
            end
            `OP_IMM: begin
                dec.valid     = 1'b1;
                dec.regWrite  = 1'b1;
                dec.aluSrcImm = 1'b1;
                dec.aluOp     = funct3ToOp(funct3, funct7Alt && funct3 == 3'b101);  // no subi
                dec.imm       = immI;
            end
            `OP_LUI: begin
                dec.valid     = 1'b1;
                dec.regWrite  = 1'b1;
                dec.aluSrcImm = 1'b1;
                dec.opASel    = selZero;
                dec.imm       = immU;
            end
            `OP_AUIPC: begin
                dec.valid     = 1'b1;
                dec.regWrite  = 1'b1;
                dec.aluSrcImm = 1'b1;
                dec.opASel    = selPc;
                dec.imm       = immU;
            end
            `OP_JAL: begin
                dec.valid    = 1'b1;
                dec.regWrite = 1'b1;
                dec.isJal    = 1'b1;
                dec.imm      = immJ;
            end
            `OP_JALR: begin
                dec.valid    = funct3 == 3'b000;
                dec.regWrite = 1'b1;
                dec.isJalr   = 1'b1;
                dec.imm      = immI;
            end
            `OP_BRANCH: begin
                dec.valid    = funct3[2:1] != 2'b01;  // 010 and 011 unused
                dec.isBranch = 1'b1;
                dec.imm      = immB;
            end
            default: ;  // bubble
        endcase
    end

endmodule

/* regFile.sv */
`timescale 1ns/100ps
`include "coreConsts.svh"

module regFile (
    input  logic            clk,
    input  logic            reset,
    input  corePkg::regIdxT rs1Idx,
    input  corePkg::regIdxT rs2Idx,
    output corePkg::xlenT   rs1Data,
    output corePkg::xlenT   rs2Data,
    input  corePkg::wbT     wb
);
    import corePkg::*;

    xlenT regs [1:`NUM_REGS-1];  // x0 is not stored

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wen && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // write in flight goes straight to the reader
    function automatic xlenT readReg(regIdxT idx);
        if (idx == '0) begin
            return '0;
        end else if (wb.wen && wb.rd == idx) begin
            return wb.data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1Data = readReg(rs1Idx);
        rs2Data = readReg(rs2Idx);
    end

endmodule

/* fetchStage.sv */
`timescale 1ns/100ps
`include "coreConsts.svh"

module fetchStage (
    input  logic              clk,
    input  logic              reset,
    output corePkg::xlenT     fetchAddr,
    input  corePkg::instrT    fetchInstr,
    output corePkg::regIdxT   rs1Idx,
    output corePkg::regIdxT   rs2Idx,
    input  corePkg::xlenT     rs1Data,
    input  corePkg::xlenT     rs2Data,
    input  corePkg::redirectT redirect,
    output corePkg::idExT     idEx
);
    import corePkg::*;

    xlenT   pc;
    xlenT   nextPc;
    decodeT dec;
    idExT   stage;

    instrDecoder decoder (
        .instr(fetchInstr),
        .dec  (dec)
    );

    assign fetchAddr = pc;
    assign rs1Idx    = dec.rs1;
    assign rs2Idx    = dec.rs2;

    // ------------------------------
    // next PC
    always_comb begin
        if (redirect.valid) begin
            nextPc = redirect.target;  // execute redirect wins over jal
        end else if (dec.valid && dec.isJal) begin
            nextPc = pc + dec.imm;
        end else begin
            nextPc = pc + 4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    // ------------------------------
    // fetch/execute register
    always_ff @(posedge clk) begin
        if (reset) begin
            stage.decode.valid <= 1'b0;
        end else begin
            stage.pc           <= pc;
            stage.instr        <= fetchInstr;
            stage.decode       <= dec;
            stage.decode.valid <= dec.valid && !redirect.valid;  // squash
            stage.rs1Data      <= rs1Data;
            stage.rs2Data      <= rs2Data;
        end
    end

    assign idEx = stage;

endmodule

/* execUnit.sv */
`timescale 1ns/100ps
`include "coreConsts.svh"

module execUnit (
    input  logic              clk,
    input  logic              reset,
    input  corePkg::idExT     idEx,
    output corePkg::redirectT redirect,
    output corePkg::wbT       wb,
    output corePkg::commitT   commit
);
    import corePkg::*;

    decodeT     dec;
    xlenT       rs1Val;
    xlenT       rs2Val;
    xlenT       opA;
    xlenT       opB;
    logic [5:0] shamt;
    xlenT       aluRes;
    xlenT       result;
    xlenT       jalrSum;
    logic       condMet;
    commitT     wbStage;

    assign dec = idEx.decode;

    // bypass from the write-back register
    function automatic xlenT forward(regIdxT idx, xlenT regVal);
        if (wbStage.wen && wbStage.rd == idx) begin
            return wbStage.data;
        end
        return regVal;
    endfunction

    always_comb begin
        rs1Val = forward(dec.rs1, idEx.rs1Data);
        rs2Val = forward(dec.rs2, idEx.rs2Data);
    end

    // ------------------------------
    // operands and ALU
    always_comb begin
        case (dec.opASel)
            selZero: opA = '0;
            selPc:   opA = idEx.pc;
            default: opA = rs1Val;
        endcase
    end

    assign opB   = dec.aluSrcImm ? dec.imm : rs2Val;
    assign shamt = opB[5:0];  // RV64 shift amount

    always_comb begin
        case (dec.aluOp)
            aluSub:  aluRes = opA - opB;
            aluAnd:  aluRes = opA & opB;
            aluOr:   aluRes = opA | opB;
            aluXor:  aluRes = opA ^ opB;
            aluSlt:  aluRes = xlenT'($signed(opA) < $signed(opB));
            aluSltu: aluRes = xlenT'(opA < opB);
            aluSll:  aluRes = opA << shamt;
            aluSrl:  aluRes = opA >> shamt;
            aluSra:  aluRes = xlenT'($signed(opA) >>> shamt);
            default: aluRes = opA + opB;
        endcase
    end

    assign result = (dec.isJal || dec.isJalr) ? idEx.pc + 4 : aluRes;  // link value

    // ------------------------------
    // branch judge and redirect
    always_comb begin
        case (dec.funct3)
            3'b000:  condMet = rs1Val == rs2Val;
            3'b001:  condMet = rs1Val != rs2Val;
            3'b100:  condMet = $signed(rs1Val) < $signed(rs2Val);
            3'b101:  condMet = $signed(rs1Val) >= $signed(rs2Val);
            3'b110:  condMet = rs1Val < rs2Val;
            default: condMet = rs1Val >= rs2Val;
        endcase
    end

    assign jalrSum = rs1Val + dec.imm;

    assign redirect.valid  = dec.valid && ((dec.isBranch && condMet) || dec.isJalr);
    assign redirect.target = dec.isJalr ? {jalrSum[`XLEN-1:1], 1'b0} : idEx.pc + dec.imm;

    // ------------------------------
    // execute/write-back register
    always_ff @(posedge clk) begin
        if (reset) begin
            wbStage.valid <= 1'b0;
            wbStage.wen   <= 1'b0;
        end else begin
            wbStage.valid <= dec.valid;
            wbStage.wen   <= dec.valid && dec.regWrite && dec.rd != '0;  // x0 never written
            wbStage.pc    <= idEx.pc;
            wbStage.instr <= idEx.instr;
            wbStage.rd    <= dec.rd;
            wbStage.data  <= result;
        end
    end

    assign wb.wen  = wbStage.wen;
    assign wb.rd   = wbStage.rd;
    assign wb.data = wbStage.data;
    assign commit  = wbStage;

endmodule

/* pipeCore.sv */
`timescale 1ns/100ps

module pipeCore (
    input  logic            clk,
    input  logic            reset,
    output corePkg::xlenT   fetchAddr,
    input  corePkg::instrT  fetchInstr,
    output corePkg::commitT commit
);
    import corePkg::*;

    regIdxT   rs1Idx;
    regIdxT   rs2Idx;
    xlenT     rs1Data;
    xlenT     rs2Data;
    idExT     idEx;
    redirectT redirect;
    wbT       wb;

    fetchStage fetch (
        .clk       (clk),
        .reset     (reset),
        .fetchAddr (fetchAddr),
        .fetchInstr(fetchInstr),
        .rs1Idx    (rs1Idx),
        .rs2Idx    (rs2Idx),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .redirect  (redirect),
        .idEx      (idEx)
    );

    regFile regs (
        .clk    (clk),
        .reset  (reset),
        .rs1Idx (rs1Idx),
        .rs2Idx (rs2Idx),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .wb     (wb)
    );

    execUnit exec (
        .clk     (clk),
        .reset   (reset),
        .idEx    (idEx),
        .redirect(redirect),
        .wb      (wb),
        .commit  (commit)
    );

endmodule

/* tbCore.sv */
`timescale 1ns/100ps
`include "coreConsts.svh"

module tbCore;
    import corePkg::*;

    localparam int PROG_LEN    = 64;
    localparam int SEED        = 15931;
    localparam int WAIT_LIMIT  = 10;
    localparam int KIND_REG    = 0;
    localparam int KIND_IMM    = 1;
    localparam int KIND_LUI    = 2;
    localparam int KIND_AUIPC  = 3;
    localparam int KIND_JAL    = 4;
    localparam int KIND_JALR   = 5;
    localparam int KIND_BRANCH = 6;

    logic   clk;
    logic   reset;
    xlenT   fetchAddr;
    instrT  fetchInstr = '0;
    commitT commit;

    // program image and the fields it was built from
    instrT  prog     [PROG_LEN];
    int     progKind [PROG_LEN];
    regIdxT progRs1  [PROG_LEN];
    regIdxT progRs2  [PROG_LEN];
    regIdxT progRd   [PROG_LEN];
    funct3T progF3   [PROG_LEN];
    logic   progAlt  [PROG_LEN];
    xlenT   progImm  [PROG_LEN];

    xlenT   modelRegs [`NUM_REGS];
    xlenT   modelPc;

    pipeCore DUT (
        .clk       (clk),
        .reset     (reset),
        .fetchAddr (fetchAddr),
        .fetchInstr(fetchInstr),
        .commit    (commit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------
    // instruction encoding
    function automatic instrT rTypeWord(logic alt, regIdxT rs2, regIdxT rs1, funct3T f3,
                                        regIdxT rd);
        return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, `OP_REG};
    endfunction

    function automatic instrT iTypeWord(logic [11:0] imm, regIdxT rs1, funct3T f3,
                                        regIdxT rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instrT uTypeWord(logic [19:0] imm, regIdxT rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic instrT jalWord(int offset, regIdxT rd);
        logic [20:0] off;
        off = 21'(offset);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OP_JAL};
    endfunction

    function automatic instrT branchWord(int offset, regIdxT rs2, regIdxT rs1, funct3T f3);
        logic [12:0] off;
        off = 13'(offset);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OP_BRANCH};
    endfunction

    function automatic xlenT signExtend12(logic [11:0] v);
        return {{(`XLEN-12){v[11]}}, v};
    endfunction

    function automatic xlenT upperImm(logic [19:0] v);
        return {{(`XLEN-32){v[19]}}, v, 12'h000};  // 32-bit value sign extended
    endfunction

    task automatic recordFields(int idx, int kind, regIdxT rs1, regIdxT rs2, regIdxT rd,
                                funct3T f3, logic alt, xlenT imm);
        progKind[idx] = kind;
        progRs1[idx]  = rs1;
        progRs2[idx]  = rs2;
        progRd[idx]   = rd;
        progF3[idx]   = f3;
        progAlt[idx]  = alt;
        progImm[idx]  = imm;
    endtask

    // ------------------------------
    // random program over x0..x7 with forward jumps
    task automatic buildProgram();
        int          pick;
        int          target;
        int          offset;
        regIdxT      rs1;
        regIdxT      rs2;
        regIdxT      rd;
        funct3T      f3;
        logic        alt;
        logic [11:0] imm12;
        logic [19:0] imm20;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            pick   = int'($urandom % 16);
            rs1    = regIdxT'($urandom % 8);
            rs2    = regIdxT'($urandom % 8);
            rd     = regIdxT'($urandom % 8);
            f3     = funct3T'($urandom % 8);
            alt    = 1'b0;
            imm20  = 20'($urandom);
            target = i + 1 + int'($urandom % 4);
            if (target > PROG_LEN - 1) begin
                target = PROG_LEN - 1;
            end
            offset = (target - i) * 4;
            if (pick < 5) begin
                if (f3 == 3'b000 || f3 == 3'b101) begin
                    alt = 1'($urandom % 2);  // sub or sra
                end
                prog[i] = rTypeWord(alt, rs2, rs1, f3, rd);
                recordFields(i, KIND_REG, rs1, rs2, rd, f3, alt, '0);
            end else if (pick < 10) begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    if (f3 == 3'b101) begin
                        alt = 1'($urandom % 2);  // srai
                    end
                    imm12 = {1'b0, alt, 4'b0000, 6'($urandom % 64)};
                end else begin
                    imm12 = 12'($urandom);
                end
                prog[i] = iTypeWord(imm12, rs1, f3, rd, `OP_IMM);
                recordFields(i, KIND_IMM, rs1, '0, rd, f3, alt, signExtend12(imm12));
            end else if (pick == 10) begin
                prog[i] = uTypeWord(imm20, rd, `OP_LUI);
                recordFields(i, KIND_LUI, '0, '0, rd, '0, 1'b0, upperImm(imm20));
            end else if (pick == 11) begin
                prog[i] = uTypeWord(imm20, rd, `OP_AUIPC);
                recordFields(i, KIND_AUIPC, '0, '0, rd, '0, 1'b0, upperImm(imm20));
            end else if (pick == 12) begin
                prog[i] = jalWord(offset, rd);
                recordFields(i, KIND_JAL, '0, '0, rd, '0, 1'b0, xlenT'(offset));
            end else if (pick == 13) begin
                imm12   = 12'(target * 4 + int'($urandom % 2));  // odd target tests bit 0 clear
                prog[i] = iTypeWord(imm12, '0, 3'b000, rd, `OP_JALR);
                recordFields(i, KIND_JALR, '0, '0, rd, '0, 1'b0, signExtend12(imm12));
            end else begin
                f3 = funct3T'($urandom % 6);
                if (f3 >= 3'd2) begin
                    f3 = f3 + 3'd2;  // skip 010 and 011
                end
                prog[i] = branchWord(offset, rs2, rs1, f3);
                recordFields(i, KIND_BRANCH, rs1, rs2, '0, f3, 1'b0, xlenT'(offset));
            end
        end
        prog[PROG_LEN-1] = jalWord(0, 5'd1);  // self loop
        recordFields(PROG_LEN - 1, KIND_JAL, '0, '0, 5'd1, '0, 1'b0, '0);
    endtask

    function automatic instrT wordAt(xlenT addr);
        if ($isunknown(addr) || addr >= xlenT'(PROG_LEN * 4)) begin
            return '0;  // decodes to a bubble
        end
        return prog[int'(addr >> 2)];
    endfunction

    always @(posedge clk) begin
        #1;
        fetchInstr = wordAt(fetchAddr);
    end

    // ------------------------------
    // ISA reference model
    function automatic xlenT aluRef(funct3T f3, logic alt, xlenT a, xlenT b);
        logic [5:0] sh;
        sh = b[5:0];
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return ($signed(a) < $signed(b)) ? xlenT'(1) : xlenT'(0);
            3'b011:  return (a < b) ? xlenT'(1) : xlenT'(0);
            3'b100:  return a ^ b;
            3'b101:  return alt ? xlenT'($signed(a) >>> sh) : a >> sh;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(funct3T f3, xlenT a, xlenT b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic modelStep(output commitT expected);
        int   idx;
        xlenT a;
        xlenT b;
        xlenT res;
        xlenT nextPc;
        logic writes;
        idx    = int'(modelPc >> 2);
        a      = modelRegs[progRs1[idx]];
        b      = modelRegs[progRs2[idx]];
        res    = '0;
        writes = 1'b1;
        nextPc = modelPc + 4;
        case (progKind[idx])
            KIND_REG:   res = aluRef(progF3[idx], progAlt[idx], a, b);
            KIND_IMM:   res = aluRef(progF3[idx], progAlt[idx], a, progImm[idx]);
            KIND_LUI:   res = progImm[idx];
            KIND_AUIPC: res = modelPc + progImm[idx];
            KIND_JAL: begin
                res    = modelPc + 4;
                nextPc = modelPc + progImm[idx];
            end
            KIND_JALR: begin
                res    = modelPc + 4;
                nextPc = (a + progImm[idx]) & ~xlenT'(1);
            end
            default: begin
                writes = 1'b0;
                if (branchTaken(progF3[idx], a, b)) begin
                    nextPc = modelPc + progImm[idx];
                end
            end
        endcase
        expected       = '0;
        expected.valid = 1'b1;
        expected.pc    = modelPc;
        expected.instr = prog[idx];
        expected.wen   = writes && progRd[idx] != '0;
        expected.rd    = progRd[idx];
        expected.data  = res;
        if (expected.wen) begin
            modelRegs[progRd[idx]] = res;
        end
        modelPc = nextPc;
    endtask

    // ------------------------------
    // checks
    task automatic failRun(string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compareXlen(string name, xlenT expected, xlenT actual);
        if (actual !== expected) begin
            failRun($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic compareInstr(string name, instrT expected, instrT actual);
        if (actual !== expected) begin
            failRun($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic compareIdx(string name, regIdxT expected, regIdxT actual);
        if (actual !== expected) begin
            failRun($sformatf("Fail %s: expected x%0d, actual x%0d", name, expected, actual));
        end
    endtask

    task automatic compareBit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            failRun($sformatf("Fail %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic waitCommit(int seq);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (commit.valid !== 1'b1) begin
            cycles++;
            if (cycles >= WAIT_LIMIT) begin
                failRun($sformatf("no commit strobe within %0d cycles for commit %0d",
                                  WAIT_LIMIT, seq));
            end
            @(negedge clk);
        end
    endtask

    task automatic checkCommit(int seq, commitT expected);
        compareXlen($sformatf("commit %0d pc", seq), expected.pc, commit.pc);
        compareInstr($sformatf("commit %0d instr", seq), expected.instr, commit.instr);
        compareBit($sformatf("commit %0d wen", seq), expected.wen, commit.wen);
        if (expected.wen) begin
            compareIdx($sformatf("commit %0d rd", seq), expected.rd, commit.rd);
            compareXlen($sformatf("commit %0d data", seq), expected.data, commit.data);
        end
    endtask

    // ------------------------------
    initial begin
        commitT expected;
        int     seq;
        int     loopCommits;
        void'($urandom(SEED));
        reset = 1'b1;
        buildProgram();
        foreach (modelRegs[i]) begin
            modelRegs[i] = '0;
        end
        modelPc     = `RESET_PC;
        seq         = 0;
        loopCommits = 0;

        @(posedge clk);
        @(negedge clk);
        compareBit("commit valid in reset", 1'b0, commit.valid);
        @(posedge clk);
        #1;
        reset = 1'b0;
        compareBit("commit valid after reset", 1'b0, commit.valid);
        compareXlen("fetch address after reset", `RESET_PC, fetchAddr);

        while (loopCommits < 3) begin
            modelStep(expected);
            waitCommit(seq);
            checkCommit(seq, expected);
            if (expected.pc == xlenT'((PROG_LEN - 1) * 4)) begin
                loopCommits++;
            end
            seq++;
        end

        $display("%0d commits checked", seq);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* build.f */
+incdir+.
corePkg.sv
instrDecoder.sv
regFile.sv
fetchStage.sv
execUnit.sv
pipeCore.sv
tbCore.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tbCore -f build.f -o simCore

./obj_dir/simCore | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
